//--- include/game_params.svh
`ifndef GAME_PARAMS_SVH
`define GAME_PARAMS_SVH

// Number of steps stored in the sequence ROM
`define GAME_SEQ_LEN 16

// Cycles per replayed step
// LED lit during the first half only
`define GAME_SHOW_CYCLES 16

// Player wait limit in timed games
`define GAME_TIMEOUT_CYCLES 48

// Tone half-period for the lowest LED
// Scaled by LED index plus one
`define GAME_TONE_BASE 2

`endif

//--- memoryGame.f
+incdir+include
source/gamePkg.sv
source/sequenceRom.sv
source/toneGenerator.sv
source/gameDatapath.sv
source/gameControl.sv
source/memoryGame.sv
sim/memoryGameTb.sv

//--- run.sh
#!/bin/sh
# Builds and runs the memory game testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

# Warnings are reported but do not stop the build
verilator --binary -Wno-fatal -f memoryGame.f --top-module memoryGameTb \
    -Mdir obj_dir -o memoryGameSim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/memoryGameSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "all tests passed" "$LOG"; then
    exit 0
fi
echo "Simulation reported failures, see $LOG"
exit 1

//--- sim/memoryGameTb.sv
`timescale 1ns/1ps

`include "game_params.svh"

module memoryGameTb;
    import gamePkg::*;

    localparam int NumGames  = 7;
    localparam int NoFail    = 0;
    localparam int WrongPlay = 1;
    localparam int Stall     = 2;

    // One scripted game per row
    typedef struct {
        logic        levelRounds;
        logic        levelTimed;
        int          failRound;
        int          failKind;
        gameResult_t expected;
    } gameRow_t;

    logic        clock;
    logic        rstN;
    logic        start;
    ledWord_t    buttons;
    logic        levelRounds;
    logic        levelTimed;
    ledWord_t    leds;
    logic        buzzer;
    logic        playerTurn;
    logic        gameOver;
    gameResult_t result;

    gameRow_t    gameTable [NumGames];
    ledWord_t    seenWords [$];
    int          errorCount;
    int          failedTests;
    int          cycleCount;
    int          cycleLimit;
    logic        monitorOn;
    ledWord_t    ledsPrev;

    memoryGame dut0 (.*);

    always #5 clock = ~clock;

    // Run limit, stops a hung game
    always @(posedge clock) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: run went past %0d cycles without finishing", cycleLimit);
            $display("tests failed");
            $finish;
        end
    end

    // Buzzer silent once LEDs have been dark for two cycles
    always @(negedge clock) begin
        if (monitorOn && ledsPrev == '0 && leds == '0 && buzzer !== 1'b0) begin
            reportMismatch("buzzer", buzzer, 0);
        end
        ledsPrev = leds;
    end

    task automatic reportMismatch(input string name, input int got, input int want);
        $display("** Error at %0t: %s is %0d, expected %0d", $time, name, got, want);
        errorCount++;
    endtask

    task automatic reportProblem(input string text);
        $display("** Error at %0t: %s", $time, text);
        errorCount++;
    endtask

    // Step a of the stored sequence, one-hot at bit (3*a) mod 4
    function automatic ledWord_t sequenceWord(input int a);
        return ledWord_t'(4'b0001 << ((3 * a) % 4));
    endfunction

    // Sum of every game's worst case, doubled
    function automatic int worstCaseCycles();
        int total;
        int rounds;
        total = 40;
        for (int g = 0; g < NumGames; g++) begin
            rounds = gameTable[g].levelRounds ? `GAME_SEQ_LEN : `GAME_SEQ_LEN / 2;
            // Replay step plus its play, per step and round
            for (int r = 0; r < rounds; r++) begin
                total += (r + 1) * (`GAME_SHOW_CYCLES + 12);
            end
            total += 3 * `GAME_TIMEOUT_CYCLES + 4 * `GAME_SHOW_CYCLES;
        end
        return 2 * total;
    endfunction

    // Follows one replay up to the player's turn or game over
    task automatic watchReplay(output logic gotTurn);
        ledWord_t prevLeds;
        logic     prevBuzzer;
        logic     toggled;
        prevLeds   = '0;
        prevBuzzer = buzzer;
        toggled    = 1'b0;
        gotTurn    = 1'b0;
        seenWords.delete();
        forever begin
            @(negedge clock);
            if (playerTurn || gameOver) begin
                gotTurn = playerTurn;
                break;
            end
            // A toggle launched while lit shows up one cycle later
            if (prevLeds != '0 && buzzer != prevBuzzer) begin
                toggled = 1'b1;
            end
            if (leds != '0 && leds != prevLeds) begin
                seenWords.push_back(leds);
            end
            if (prevLeds != '0 && leds == '0) begin
                if (!toggled) begin
                    reportProblem("buzzer never toggled during a lit replay step");
                end
                toggled = 1'b0;
            end
            prevLeds   = leds;
            prevBuzzer = buzzer;
        end
    endtask

    task automatic checkReplay(input int r);
        if (seenWords.size() != r + 1) begin
            reportMismatch("replay length", seenWords.size(), r + 1);
        end else begin
            for (int s = 0; s <= r; s++) begin
                if (seenWords[s] !== sequenceWord(s)) begin
                    reportMismatch("leds", seenWords[s], sequenceWord(s));
                end
            end
        end
    endtask

    task automatic waitTurn(output logic gotTurn);
        do begin
            @(negedge clock);
        end while (!playerTurn && !gameOver);
        gotTurn = playerTurn;
    endtask

    task automatic waitGameOver(input int limit, output logic reached);
        reached = gameOver;
        for (int k = 0; k < limit && !reached; k++) begin
            @(negedge clock);
            reached = gameOver;
        end
    endtask

    // Press held until playerTurn drops, at least two cycles
    task automatic pressButton(input ledWord_t word);
        logic fell;
        fell    = 1'b0;
        buttons = word;
        for (int k = 0; k < 3 && !fell; k++) begin
            @(negedge clock);
            fell = !playerTurn;
        end
        if (!fell) begin
            reportProblem("playerTurn stayed high for 3 cycles after a play");
        end
        buttons = '0;
    endtask

    // One player step, misplayed or stalled where the row says so
    task automatic playStep(input gameRow_t row, input int r, input int s, inout logic ended);
        logic     quiet;
        logic     reached;
        ledWord_t wrongWord;
        int       wrongIdx;
        quiet = 1'b1;
        if (row.failKind == Stall && r == row.failRound && s == 0 && row.levelTimed) begin
            waitGameOver(2 * `GAME_TIMEOUT_CYCLES, reached);
            if (!reached) begin
                reportProblem("timed game did not end while the player stalled");
            end
            ended = 1'b1;
        end else if (row.failKind == WrongPlay && r == row.failRound && s == r) begin
            // Any one-hot word but the right one
            wrongIdx  = ((3 * s) % 4 + 1 + int'($urandom % 3)) % 4;
            wrongWord = ledWord_t'(4'b0001 << wrongIdx);
            pressButton(wrongWord);
            waitGameOver(4, reached);
            if (!reached) begin
                reportProblem("wrong button did not end the game");
            end
            ended = 1'b1;
        end else begin
            if (row.failKind == Stall && r == row.failRound && s == 0) begin
                // Untimed stall, turn must hold
                repeat (3 * `GAME_TIMEOUT_CYCLES) begin
                    @(negedge clock);
                    if (gameOver || !playerTurn) begin
                        quiet = 1'b0;
                    end
                end
                if (!quiet) begin
                    reportProblem("untimed game left the player's turn during a stall");
                end
            end
            pressButton(sequenceWord(s));
        end
    endtask

    // Result held, no more replay after game over
    task automatic checkFinish(input gameResult_t expected);
        logic quiet;
        quiet = 1'b1;
        if (result !== expected) begin
            reportMismatch("result", result, expected);
        end
        repeat (2 * `GAME_SHOW_CYCLES) begin
            @(negedge clock);
            if (!gameOver || leds != '0) begin
                quiet = 1'b0;
            end
        end
        if (!quiet) begin
            reportProblem("outputs changed after the game ended");
        end
    endtask

    task automatic playGame(input int g);
        gameRow_t row;
        int       rounds;
        int       startErrors;
        logic     gotTurn;
        logic     ended;
        logic     reached;
        row         = gameTable[g];
        rounds      = row.levelRounds ? `GAME_SEQ_LEN : `GAME_SEQ_LEN / 2;
        startErrors = errorCount;
        ended       = 1'b0;
        levelRounds = row.levelRounds;
        levelTimed  = row.levelTimed;
        start       = 1'b1;
        @(negedge clock);
        start = 1'b0;
        // Start clears the previous game's result
        if (result !== none) begin
            reportMismatch("result", result, none);
        end
        for (int r = 0; r < rounds && !ended; r++) begin
            watchReplay(gotTurn);
            if (!gotTurn) begin
                reportProblem($sformatf("game ended before round %0d was played", r));
                ended = 1'b1;
            end else begin
                checkReplay(r);
            end
            for (int s = 0; s <= r && !ended; s++) begin
                if (s > 0) begin
                    waitTurn(gotTurn);
                    if (!gotTurn) begin
                        reportProblem($sformatf("game ended inside round %0d", r));
                        ended = 1'b1;
                    end
                end
                if (!ended) begin
                    playStep(row, r, s, ended);
                end
            end
        end
        if (!ended) begin
            waitGameOver(8, reached);
            if (!reached) begin
                reportProblem("game did not end after the last round");
            end
        end
        checkFinish(row.expected);
        if (errorCount != startErrors) begin
            failedTests++;
        end
        $display("test game %0d: rounds %0d, timed %0b, errors %0d", g, rounds,
                 row.levelTimed, errorCount - startErrors);
    endtask

    initial begin
        clock       = 1'b0;
        rstN        = 1'b0;
        start       = 1'b0;
        buttons     = '0;
        levelRounds = 1'b0;
        levelTimed  = 1'b0;
        errorCount  = 0;
        failedTests = 0;
        cycleCount  = 0;
        monitorOn   = 1'b0;
        ledsPrev    = '0;
        void'($urandom(81));
        // levelRounds, levelTimed, fail round, fail kind, result
        gameTable[0] = '{1'b0, 1'b0, -1, NoFail, won};
        gameTable[1] = '{1'b1, 1'b0, -1, NoFail, won};
        gameTable[2] = '{1'b0, 1'b0, 3, WrongPlay, lost};
        gameTable[3] = '{1'b1, 1'b1, 0, WrongPlay, lost};
        gameTable[4] = '{1'b0, 1'b1, 2, Stall, timedOut};
        gameTable[5] = '{1'b0, 1'b0, 1, Stall, won};
        gameTable[6] = '{1'b0, 1'b1, -1, NoFail, won};
        cycleLimit = worstCaseCycles();
        repeat (4) @(negedge clock);
        rstN = 1'b1;
        @(negedge clock);
        monitorOn = 1'b1;
        // Idle outputs after reset
        if (leds !== '0) begin
            reportMismatch("leds", leds, 0);
        end
        if (buzzer !== 1'b0) begin
            reportMismatch("buzzer", buzzer, 0);
        end
        if (playerTurn !== 1'b0) begin
            reportMismatch("playerTurn", playerTurn, 0);
        end
        if (gameOver !== 1'b0) begin
            reportMismatch("gameOver", gameOver, 0);
        end
        if (result !== none) begin
            reportMismatch("result", result, none);
        end
        if (errorCount != 0) begin
            failedTests++;
        end
        $display("test reset: errors %0d", errorCount);
        for (int g = 0; g < NumGames; g++) begin
            playGame(g);
        end
        $display("tests run %0d, tests with errors %0d, errors %0d", NumGames + 1,
                 failedTests, errorCount);
        if (errorCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- source/gameControl.sv
`timescale 1ns/1ps

module gameControl (
    input  logic                 clock,
    input  logic                 rstN,
    input  logic                 start,
    input  logic                 playMade,
    input  logic                 playCorrect,
    input  logic                 stepIsRound,
    input  logic                 lastRound,
    input  logic                 showHalf,
    input  logic                 showDone,
    input  logic                 timeoutDone,
    output logic                 clearRound,
    output logic                 countRound,
    output logic                 clearStep,
    output logic                 countStep,
    output logic                 loadLevels,
    output logic                 loadPlay,
    output logic                 clearShow,
    output logic                 countShow,
    output logic                 clearTimeout,
    output logic                 countTimeout,
    output logic                 showLeds,
    output logic                 playerTurn,
    output logic                 gameOver,
    output gamePkg::gameResult_t result
);
    import gamePkg::*;

    gameState_t  state;
    gameState_t  stateNext;
    gameResult_t resultNext;
    logic        resultLoad;

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            state <= idle;
        end else begin
            state <= stateNext;
        end
    end

    // Result held through finish, cleared by the next start
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            result <= none;
        end else if (resultLoad) begin
            result <= resultNext;
        end
    end

    always_comb begin
        stateNext    = state;
        resultLoad   = 1'b0;
        resultNext   = none;
        clearRound   = 1'b0;
        countRound   = 1'b0;
        clearStep    = 1'b0;
        countStep    = 1'b0;
        loadLevels   = 1'b0;
        loadPlay     = 1'b0;
        clearShow    = 1'b0;
        countShow    = 1'b0;
        clearTimeout = 1'b0;
        countTimeout = 1'b0;
        showLeds     = 1'b0;
        case (state)
            idle, finish: begin
                if (start) begin
                    resultLoad = 1'b1;
                    stateNext  = gamePkg::loadLevels;
                end
            end
            gamePkg::loadLevels: begin
                // Fresh game from round 0, step 0
                loadLevels   = 1'b1;
                clearRound   = 1'b1;
                clearStep    = 1'b1;
                clearShow    = 1'b1;
                clearTimeout = 1'b1;
                stateNext    = nextShow;
            end
            nextShow: begin
                // ROM settles on the new address here
                clearShow = 1'b1;
                stateNext = showStep;
            end
            showStep: begin
                showLeds  = 1'b1;
                countShow = 1'b1;
                if (showHalf) begin
                    stateNext = showGap;
                end
            end
            showGap: begin
                countShow = 1'b1;
                if (showDone) begin
                    if (stepIsRound) begin
                        // Replay over, player starts from step 0
                        clearStep    = 1'b1;
                        clearTimeout = 1'b1;
                        stateNext    = waitPlay;
                    end else begin
                        countStep = 1'b1;
                        stateNext = nextShow;
                    end
                end
            end
            waitPlay: begin
                countTimeout = 1'b1;
                if (playMade) begin
                    loadPlay  = 1'b1;
                    stateNext = checkPlay;
                end else if (timeoutDone) begin
                    resultLoad = 1'b1;
                    resultNext = timedOut;
                    stateNext  = finish;
                end
            end
            checkPlay: begin
                if (!playCorrect) begin
                    resultLoad = 1'b1;
                    resultNext = lost;
                    stateNext  = finish;
                end else if (stepIsRound) begin
                    if (lastRound) begin
                        resultLoad = 1'b1;
                        resultNext = won;
                        stateNext  = finish;
                    end else begin
                        stateNext = nextRound;
                    end
                end else begin
                    countStep = 1'b1;
                    stateNext = nextStep;
                end
            end
            nextStep: begin
                // One state for the ROM to follow countStep
                clearTimeout = 1'b1;
                stateNext    = waitPlay;
            end
            nextRound: begin
                countRound = 1'b1;
                clearStep  = 1'b1;
                stateNext  = nextShow;
            end
            default: begin
                stateNext = idle;
            end
        endcase
    end

    assign playerTurn = (state == waitPlay);
    assign gameOver   = (state == finish);

endmodule

//--- source/gameDatapath.sv
`timescale 1ns/1ps

`include "game_params.svh"

module gameDatapath (
    input  logic              clock,
    input  logic              rstN,
    input  gamePkg::ledWord_t buttons,
    input  logic              levelRounds,
    input  logic              levelTimed,
    input  logic              clearRound,
    input  logic              countRound,
    input  logic              clearStep,
    input  logic              countStep,
    input  logic              loadLevels,
    input  logic              loadPlay,
    input  logic              clearShow,
    input  logic              countShow,
    input  logic              clearTimeout,
    input  logic              countTimeout,
    input  logic              showLeds,
    output gamePkg::ledWord_t leds,
    output logic              playMade,
    output logic              playCorrect,
    output logic              stepIsRound,
    output logic              lastRound,
    output logic              showHalf,
    output logic              showDone,
    output logic              timeoutDone,
    output logic              levelTimedReg
);
    import gamePkg::*;

    localparam int ShowBits    = $clog2(`GAME_SHOW_CYCLES);
    localparam int TimeoutBits = $clog2(`GAME_TIMEOUT_CYCLES);

    logic                   levelRoundsReg;
    ledWord_t               buttonReg;
    logic                   anyPrev;
    ledWord_t               playWord;
    stepIdx_t               stepCount;
    stepIdx_t               roundCount;
    ledWord_t               romWord;
    logic [ShowBits-1:0]    showCount;
    logic [TimeoutBits-1:0] timeoutCount;

    // Levels are sampled once per game
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            levelRoundsReg <= 1'b0;
            levelTimedReg  <= 1'b0;
        end else if (loadLevels) begin
            levelRoundsReg <= levelRounds;
            levelTimedReg  <= levelTimed;
        end
    end

    // Buttons registered, then rising edge of their OR
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            buttonReg <= '0;
            anyPrev   <= 1'b0;
        end else begin
            buttonReg <= buttons;
            anyPrev   <= |buttonReg;
        end
    end

    assign playMade = (|buttonReg) & ~anyPrev;

    // Play word, taken from the registered buttons
    always_ff @(posedge clock) begin
        if (loadPlay) begin
            playWord <= buttonReg;
        end
    end

    // Step address and round counters
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            stepCount  <= '0;
            roundCount <= '0;
        end else begin
            if (clearStep) begin
                stepCount <= '0;
            end else if (countStep) begin
                stepCount <= stepCount + 4'd1;
            end
            if (clearRound) begin
                roundCount <= '0;
            end else if (countRound) begin
                roundCount <= roundCount + 4'd1;
            end
        end
    end

    sequenceRom sequenceRom0 (
        .clock   (clock),
        .address (stepCount),
        .data    (romWord)
    );

    // Sequence path compares
    assign playCorrect = (romWord == playWord);
    assign stepIsRound = (stepCount == roundCount);
    // Round 15 in a full game, round 7 in a short one
    assign lastRound   = levelRoundsReg ? (roundCount == stepIdx_t'(`GAME_SEQ_LEN - 1))
                                        : (roundCount == stepIdx_t'(`GAME_SEQ_LEN / 2 - 1));

    // Show timer, one replay step
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            showCount <= '0;
        end else if (clearShow) begin
            showCount <= '0;
        end else if (countShow) begin
            showCount <= showCount + 1'b1;
        end
    end

    // Last lit cycle and last dark cycle of the step
    assign showHalf = (showCount == ShowBits'(`GAME_SHOW_CYCLES / 2 - 1));
    assign showDone = (showCount == ShowBits'(`GAME_SHOW_CYCLES - 1));

    // Timeout timer, restarted by any play
    // Saturates so an untimed game never wraps
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            timeoutCount <= '0;
        end else if (clearTimeout || playMade) begin
            timeoutCount <= '0;
        end else if (countTimeout && !(timeoutCount == TimeoutBits'(`GAME_TIMEOUT_CYCLES - 1))) begin
            timeoutCount <= timeoutCount + 1'b1;
        end
    end

    // Only counts in timed games
    assign timeoutDone = levelTimedReg
                       && (timeoutCount == TimeoutBits'(`GAME_TIMEOUT_CYCLES - 1));

    // LEDs dark unless the control is showing a step
    assign leds = showLeds ? romWord : '0;

endmodule

//--- source/gamePkg.sv
package gamePkg;

    // Control FSM states, one word of 4 bits
    typedef enum logic [3:0] {
        idle,
        loadLevels,
        showStep,
        showGap,
        nextShow,
        waitPlay,
        checkPlay,
        nextStep,
        nextRound,
        finish
    } gameState_t;

    // Outcome of a game, none while running
    typedef enum logic [1:0] {
        none,
        won,
        lost,
        timedOut
    } gameResult_t;

    // LED pattern or button word, one bit per color
    typedef logic [3:0] ledWord_t;

    // Step address and round index
    typedef logic [3:0] stepIdx_t;

endpackage

//--- source/memoryGame.sv
`timescale 1ns/1ps

module memoryGame (
    input  logic                 clock,
    input  logic                 rstN,
    input  logic                 start,
    input  gamePkg::ledWord_t    buttons,
    input  logic                 levelRounds,
    input  logic                 levelTimed,
    output gamePkg::ledWord_t    leds,
    output logic                 buzzer,
    output logic                 playerTurn,
    output logic                 gameOver,
    output gamePkg::gameResult_t result
);
    // Control strobes into the datapath
    logic clearRound;
    logic countRound;
    logic clearStep;
    logic countStep;
    logic loadLevels;
    logic loadPlay;
    logic clearShow;
    logic countShow;
    logic clearTimeout;
    logic countTimeout;
    logic showLeds;

    // Conditions back to the control
    logic playMade;
    logic playCorrect;
    logic stepIsRound;
    logic lastRound;
    logic showHalf;
    logic showDone;
    logic timeoutDone;

    gameControl control0 (.*);

    // Timed level is already folded into timeoutDone
    gameDatapath datapath0 (
        .*,
        .levelTimedReg ()
    );

    // Tone follows whichever LED is lit
    toneGenerator tone0 (.*);

endmodule

//--- source/sequenceRom.sv
`timescale 1ns/1ps

`include "game_params.svh"

module sequenceRom (
    input  logic              clock,
    input  gamePkg::stepIdx_t address,
    output gamePkg::ledWord_t data
);
    import gamePkg::*;

    ledWord_t romTable [`GAME_SEQ_LEN];

    // Contents follow a fixed rule
    // Word a is one-hot with bit (3*a) mod 4 set
    always_comb begin
        for (int a = 0; a < `GAME_SEQ_LEN; a++) begin
            romTable[a] = ledWord_t'(1) << ((3 * a) % 4);
        end
    end

    // Registered read, data lags the address by one cycle
    always_ff @(posedge clock) begin
        data <= romTable[address];
    end

endmodule

//--- source/toneGenerator.sv
`timescale 1ns/1ps

`include "game_params.svh"

module toneGenerator (
    input  logic              clock,
    input  logic              rstN,
    input  gamePkg::ledWord_t leds,
    output logic              buzzer
);
    logic [1:0] litIndex;
    logic [3:0] halfPeriod;
    logic [3:0] halfCount;

    // Index of the lit LED
    // Highest bit wins, though only one is ever set
    always_comb begin
        litIndex = 2'd0;
        for (int i = 0; i < 4; i++) begin
            if (leds[i]) begin
                litIndex = 2'(i);
            end
        end
    end

    // Lower LED gives the higher pitch
    assign halfPeriod = 4'(`GAME_TONE_BASE) * (4'(litIndex) + 4'd1);

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            halfCount <= '0;
            buzzer    <= 1'b0;
        end else if (leds == '0) begin
            // Silent and restarted while dark
            halfCount <= '0;
            buzzer    <= 1'b0;
        end else if (halfCount >= halfPeriod - 4'd1) begin
            // Also catches a count left over from a longer period
            halfCount <= '0;
            buzzer    <= ~buzzer;
        end else begin
            halfCount <= halfCount + 4'd1;
        end
    end

endmodule
